/* rtl/asym_cfg_pkg.sv */
// asymmetric memory configuration
// default port widths, byte order and the width helpers used to size lanes

package asym_cfg_pkg;

   // default configuration: 32-bit write, 8-bit read
   localparam int DEF_W_DATA_W = 32;
   localparam int DEF_R_DATA_W = 8;

   // address width counted in narrow words
   localparam int DEF_ADDR_W = 8;

   // which lane holds the lowest narrow address of a wide word
   typedef enum logic {
      BO_LITTLE = 1'b0,
      BO_BIG    = 1'b1
   } byte_order_e;

   // wider of the two port widths
   function automatic int width_max(input int a, input int b);
      if (a > b) begin
         return a;
      end
      return b;
   endfunction

   // narrower of the two port widths, one lane wide
   function automatic int width_min(input int a, input int b);
      if (a < b) begin
         return a;
      end
      return b;
   endfunction

   // number of narrow lanes in one wide word
   function automatic int width_ratio(input int a, input int b);
      int wide;
      int narrow;
      wide   = width_max(a, b);
      narrow = width_min(a, b);
      return wide / narrow;
   endfunction

endpackage

/* rtl/mem_ctrl_pkg.sv */
// memory control types
// clearer state encoding and the lane enable mask

package mem_ctrl_pkg;

   // clearing sequencer states
   typedef enum logic {
      CLR_RUN  = 1'b0,
      CLR_IDLE = 1'b1
   } clr_state_e;

   // one-hot lane mask, one bit per lane, room for up to 8 lanes
   typedef logic [7:0] lane_sel_t;

endpackage

/* rtl/lane_mem_if.sv */
// lane memory bus
// per-lane enables with shared addresses and lane-packed data

`timescale 1ns/100ps

interface lane_mem_if
   import mem_ctrl_pkg::*;
#(
   parameter int R         = $bits(lane_sel_t),
   parameter int MINDATA_W = 8,
   parameter int MINADDR_W = 8 - $clog2(R)
);

   // write side, one enable bit per lane
   logic [R-1:0]           w_en;
   logic [MINADDR_W-1:0]   w_addr;
   logic [R*MINDATA_W-1:0] w_data;

   // read side, data arrives one cycle after the enable
   logic [R-1:0]           r_en;
   logic [MINADDR_W-1:0]   r_addr;
   logic [R*MINDATA_W-1:0] r_data;

   modport ctrl (
      output w_en,
      output w_addr,
      output w_data,
      output r_en,
      output r_addr,
      input  r_data
   );

   modport ram (
      input  w_en,
      input  w_addr,
      input  w_data,
      input  r_en,
      input  r_addr,
      output r_data
   );

endinterface

/* rtl/asym_port_converter.sv */
// asymmetric port converter
// splits or gathers port words across the narrow lanes and holds the last read word

`timescale 1ns/100ps

module asym_port_converter
   import asym_cfg_pkg::*;
   import mem_ctrl_pkg::*;
#(
   parameter int          W_DATA_W   = DEF_W_DATA_W,
   parameter int          R_DATA_W   = DEF_R_DATA_W,
   parameter int          ADDR_W     = DEF_ADDR_W,
   parameter byte_order_e BYTE_ORDER = BO_LITTLE,
   localparam int MAXDATA_W = width_max(W_DATA_W, R_DATA_W),
   localparam int MINDATA_W = width_min(W_DATA_W, R_DATA_W),
   localparam int R         = width_ratio(W_DATA_W, R_DATA_W),
   localparam int MINADDR_W = ADDR_W - $clog2(R),
   localparam int W_ADDR_W  = (W_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W,
   localparam int R_ADDR_W  = (R_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W
) (
   input  logic                clk_i,
   input  logic                arst_n_i,
   input  logic                w_en_i,
   input  logic [W_ADDR_W-1:0] w_addr_i,
   input  logic [W_DATA_W-1:0] w_data_i,
   input  logic                r_en_i,
   input  logic [R_ADDR_W-1:0] r_addr_i,
   output logic [R_DATA_W-1:0] r_data_o,
   lane_mem_if.ctrl            mem
);

   typedef logic [MAXDATA_W-1:0] wide_t;

   logic  r_valid_q;
   wide_t r_hold_q;
   wide_t r_data_int;

   // ram data is valid the cycle after a read strobe
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         r_valid_q <= 1'b0;
      end else begin
         r_valid_q <= r_en_i;
      end
   end

   // keep the last word read until the next read completes
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         r_hold_q <= '0;
      end else if (r_valid_q) begin
         r_hold_q <= mem.r_data;
      end
   end

   // fresh data goes straight through, otherwise the held copy
   assign r_data_int = r_valid_q ? mem.r_data : r_hold_q;

   if (W_DATA_W > R_DATA_W) begin : g_write_wider
      localparam int LSB_W = $clog2(R);

      logic [LSB_W-1:0] rd_lane;
      logic [LSB_W-1:0] rd_lane_q;
      lane_sel_t        rd_sel;

      // a wide write fills every lane at once
      assign mem.w_en   = {R{w_en_i}};
      assign mem.w_addr = w_addr_i;
      assign mem.w_data = w_data_i;

      // R is a power of two, so the mirrored lane is the inverted index
      if (BYTE_ORDER == BO_BIG) begin : g_big
         assign rd_lane = ~r_addr_i[LSB_W-1:0];
      end else begin : g_little
         assign rd_lane = r_addr_i[LSB_W-1:0];
      end

      assign rd_sel     = lane_sel_t'(r_en_i) << rd_lane;
      assign mem.r_en   = rd_sel[R-1:0];
      assign mem.r_addr = r_addr_i[R_ADDR_W-1:LSB_W];

      // lane to pick when the data comes back
      always_ff @(posedge clk_i or negedge arst_n_i) begin
         if (!arst_n_i) begin
            rd_lane_q <= '0;
         end else if (r_en_i) begin
            rd_lane_q <= rd_lane;
         end
      end

      assign r_data_o = r_data_int[rd_lane_q*MINDATA_W +: MINDATA_W];

   end else if (W_DATA_W < R_DATA_W) begin : g_read_wider
      localparam int LSB_W = $clog2(R);

      logic [LSB_W-1:0] wr_lane;
      lane_sel_t        wr_sel;

      // narrow write goes to one lane, data shifted into that slot
      assign wr_lane    = w_addr_i[LSB_W-1:0];
      assign wr_sel     = lane_sel_t'(w_en_i) << wr_lane;
      assign mem.w_en   = wr_sel[R-1:0];
      assign mem.w_addr = w_addr_i[W_ADDR_W-1:LSB_W];
      assign mem.w_data = wide_t'(w_data_i) << (wr_lane * MINDATA_W);

      // a wide read takes all lanes
      assign mem.r_en   = {R{r_en_i}};
      assign mem.r_addr = r_addr_i;

      if (BYTE_ORDER == BO_BIG) begin : g_big
         // lowest address ends up in the top slot of the read word
         for (genvar i = 0; i < R; i++) begin : g_lane
            assign r_data_o[i*MINDATA_W +: MINDATA_W] =
               r_data_int[(R-1-i)*MINDATA_W +: MINDATA_W];
         end
      end else begin : g_little
         assign r_data_o = r_data_int;
      end

   end else begin : g_same_width
      // single lane, nothing to split
      assign mem.w_en   = w_en_i;
      assign mem.w_addr = w_addr_i;
      assign mem.w_data = w_data_i;
      assign mem.r_en   = r_en_i;
      assign mem.r_addr = r_addr_i;
      assign r_data_o   = r_data_int;
   end

endmodule

/* rtl/mem_clear_ctrl.sv */
// memory clear sequencer
// zeroes every lane address after reset, then passes the lane bus through

`timescale 1ns/100ps

module mem_clear_ctrl
   import asym_cfg_pkg::*;
   import mem_ctrl_pkg::*;
#(
   parameter int R         = width_ratio(DEF_W_DATA_W, DEF_R_DATA_W),
   parameter int MINDATA_W = width_min(DEF_W_DATA_W, DEF_R_DATA_W),
   parameter int MINADDR_W = DEF_ADDR_W - $clog2(R)
) (
   input  logic     clk_i,
   input  logic     arst_n_i,
   lane_mem_if.ram  up,
   lane_mem_if.ctrl down,
   output logic     clear_busy_o
);

   typedef logic [MINADDR_W-1:0] lane_addr_t;

   clr_state_e state_q;
   lane_addr_t clr_addr_q;
   logic       rd_mask_q;

   // one address per cycle, idle once the last one is written
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q    <= CLR_RUN;
         clr_addr_q <= '0;
      end else if (state_q == CLR_RUN) begin
         clr_addr_q <= clr_addr_q + lane_addr_t'(1);
         if (&clr_addr_q) begin
            state_q <= CLR_IDLE;
         end
      end
   end

   // data returning the cycle after clearing belongs to a blocked read
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_mask_q <= 1'b1;
      end else begin
         rd_mask_q <= (state_q == CLR_RUN);
      end
   end

   always_comb begin
      if (state_q == CLR_RUN) begin
         // all lanes written with zero, port strobes dropped
         down.w_en   = '1;
         down.w_addr = clr_addr_q;
         down.w_data = '0;
         down.r_en   = '0;
         down.r_addr = '0;
      end else begin
         down.w_en   = up.w_en;
         down.w_addr = up.w_addr;
         down.w_data = up.w_data;
         down.r_en   = up.r_en;
         down.r_addr = up.r_addr;
      end
   end

   // blocked reads return zero instead of stale lane registers
   assign up.r_data = rd_mask_q ? '0 : down.r_data;

   assign clear_busy_o = (state_q == CLR_RUN);

endmodule

/* rtl/lane_ram.sv */
// lane RAM
// R independent narrow lanes, synchronous read-first with one cycle latency

`timescale 1ns/100ps

module lane_ram
   import asym_cfg_pkg::*;
#(
   parameter int R         = width_ratio(DEF_W_DATA_W, DEF_R_DATA_W),
   parameter int MINDATA_W = width_min(DEF_W_DATA_W, DEF_R_DATA_W),
   parameter int MINADDR_W = DEF_ADDR_W - $clog2(R)
) (
   input logic     clk_i,
   lane_mem_if.ram mem
);

   localparam int DEPTH = 2**MINADDR_W;

   typedef logic [MINDATA_W-1:0] lane_word_t;

   for (genvar i = 0; i < R; i++) begin : g_lane
      lane_word_t ram_q [DEPTH];
      lane_word_t rd_q;

      // write under this lane's own enable
      always_ff @(posedge clk_i) begin
         if (mem.w_en[i]) begin
            ram_q[mem.w_addr] <= mem.w_data[i*MINDATA_W +: MINDATA_W];
         end
      end

      // read sees the word as it was before a same-edge write
      always_ff @(posedge clk_i) begin
         if (mem.r_en[i]) begin
            rd_q <= ram_q[mem.r_addr];
         end
      end

      assign mem.r_data[i*MINDATA_W +: MINDATA_W] = rd_q;
   end

endmodule

/* rtl/asym_mem_top.sv */
// asymmetric dual-port memory
// converter, clear sequencer and lane RAM behind plain write and read ports

`timescale 1ns/100ps

module asym_mem_top
   import asym_cfg_pkg::*;
#(
   parameter int          W_DATA_W   = DEF_W_DATA_W,
   parameter int          R_DATA_W   = DEF_R_DATA_W,
   parameter int          ADDR_W     = DEF_ADDR_W,
   parameter byte_order_e BYTE_ORDER = BO_LITTLE,
   localparam int MAXDATA_W = width_max(W_DATA_W, R_DATA_W),
   localparam int MINDATA_W = width_min(W_DATA_W, R_DATA_W),
   localparam int R         = width_ratio(W_DATA_W, R_DATA_W),
   localparam int MINADDR_W = ADDR_W - $clog2(R),
   localparam int W_ADDR_W  = (W_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W,
   localparam int R_ADDR_W  = (R_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W
) (
   input  logic                clk_i,
   input  logic                arst_n_i,
   input  logic                w_en_i,
   input  logic [W_ADDR_W-1:0] w_addr_i,
   input  logic [W_DATA_W-1:0] w_data_i,
   input  logic                r_en_i,
   input  logic [R_ADDR_W-1:0] r_addr_i,
   output logic [R_DATA_W-1:0] r_data_o,
   output logic                clear_busy_o
);

   // converter to clearer
   lane_mem_if #(
      .R        (R),
      .MINDATA_W(MINDATA_W),
      .MINADDR_W(MINADDR_W)
   ) conv_bus ();

   // clearer to lane RAM
   lane_mem_if #(
      .R        (R),
      .MINDATA_W(MINDATA_W),
      .MINADDR_W(MINADDR_W)
   ) ram_bus ();

   asym_port_converter #(
      .W_DATA_W  (W_DATA_W),
      .R_DATA_W  (R_DATA_W),
      .ADDR_W    (ADDR_W),
      .BYTE_ORDER(BYTE_ORDER)
   ) i_port_converter (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .w_en_i  (w_en_i),
      .w_addr_i(w_addr_i),
      .w_data_i(w_data_i),
      .r_en_i  (r_en_i),
      .r_addr_i(r_addr_i),
      .r_data_o(r_data_o),
      .mem     (conv_bus.ctrl)
   );

   mem_clear_ctrl #(
      .R        (R),
      .MINDATA_W(MINDATA_W),
      .MINADDR_W(MINADDR_W)
   ) i_clear_ctrl (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .up          (conv_bus.ram),
      .down        (ram_bus.ctrl),
      .clear_busy_o(clear_busy_o)
   );

   lane_ram #(
      .R        (R),
      .MINDATA_W(MINDATA_W),
      .MINADDR_W(MINADDR_W)
   ) i_lane_ram (
      .clk_i(clk_i),
      .mem  (ram_bus.ram)
   );

endmodule

/* sim/asym_mem_tb.sv */
// asymmetric memory testbench
// file-driven cases, then LFSR traffic checked against a narrow-word model

`timescale 1ns/100ps

module asym_mem_tb
   import asym_cfg_pkg::*;
();

   localparam int W_W          = DEF_W_DATA_W;
   localparam int R_W          = DEF_R_DATA_W;
   localparam int LANES        = W_W / R_W;
   localparam int NARROW_DEPTH = 2**DEF_ADDR_W;
   localparam int WIDE_ADDR_W  = DEF_ADDR_W - $clog2(LANES);
   localparam int CLR_CYCLES   = 2**WIDE_ADDR_W;
   localparam int N_RAND       = 200;
   localparam int MAX_CASES    = 64;
   localparam int NAME_W       = 8*24;
   localparam int BLOCKED_AT   = 10;
   localparam int MARGIN       = 40;

   logic                   clk_i;
   logic                   arst_n_i;
   logic                   w_en_i;
   logic [WIDE_ADDR_W-1:0] w_addr_i;
   logic [W_W-1:0]         w_data_i;
   logic                   r_en_i;
   logic [DEF_ADDR_W-1:0]  r_addr_i;
   logic [R_W-1:0]         r_data_o;
   logic                   clear_busy_o;

   // narrow-word reference model and last expected read word
   logic [R_W-1:0] model_mem [NARROW_DEPTH];
   logic [R_W-1:0] last_rd;
   logic [31:0]    lfsr_state;

   logic [NAME_W-1:0] case_name [MAX_CASES];
   logic [8*8-1:0]    case_op   [MAX_CASES];
   logic [31:0]       case_addr [MAX_CASES];
   logic [31:0]       case_data [MAX_CASES];
   logic [31:0]       case_exp  [MAX_CASES];

   int n_cases     = 0;
   int value_errs  = 0;
   int other_errs  = 0;
   int cycle_cnt   = 0;
   int cycle_limit = 100000;

   asym_mem_top #(
      .W_DATA_W  (W_W),
      .R_DATA_W  (R_W),
      .ADDR_W    (DEF_ADDR_W),
      .BYTE_ORDER(BO_LITTLE)
   ) i_asym_mem_top (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .w_en_i      (w_en_i),
      .w_addr_i    (w_addr_i),
      .w_data_i    (w_data_i),
      .r_en_i      (r_en_i),
      .r_addr_i    (r_addr_i),
      .r_data_o    (r_data_o),
      .clear_busy_o(clear_busy_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
   endtask

   task automatic check_value(input logic [NAME_W-1:0] name, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
      assert (act_v === exp_v) else begin
         value_errs++;
         $display("[FAIL] %0s: expected %0h, actual %0h", name, exp_v, act_v);
      end
   endtask

   // little endian, byte 0 lands on the lowest narrow address
   task automatic model_write(input logic [WIDE_ADDR_W-1:0] addr, input logic [W_W-1:0] data);
      for (int i = 0; i < LANES; i++) begin
         model_mem[addr*LANES + i] = data[i*R_W +: R_W];
      end
   endtask

   task automatic write_word(input logic [WIDE_ADDR_W-1:0] addr, input logic [W_W-1:0] data);
      w_addr_i = addr;
      w_data_i = data;
      w_en_i   = 1'b1;
      @(negedge clk_i);
      w_en_i = 1'b0;
      model_write(addr, data);
   endtask

   task automatic read_check(input logic [NAME_W-1:0] name, input logic [DEF_ADDR_W-1:0] addr,
                             input logic [R_W-1:0] exp_v);
      r_addr_i = addr;
      r_en_i   = 1'b1;
      @(negedge clk_i);
      r_en_i = 1'b0;
      check_value(name, exp_v, r_data_o);
      last_rd = exp_v;
   endtask

   // read port must keep its word while idle
   task automatic hold_check(input logic [NAME_W-1:0] name, input int cycles,
                             input logic [R_W-1:0] exp_v);
      for (int i = 0; i < cycles; i++) begin
         @(negedge clk_i);
         check_value(name, exp_v, r_data_o);
      end
   endtask

   task automatic load_cases();
      int                fd;
      int                cnt;
      logic [8*128-1:0]  line;
      logic [NAME_W-1:0] name;
      logic [8*8-1:0]    op;
      logic [31:0]       addr;
      logic [31:0]       data;
      logic [31:0]       exp_v;
      fd = $fopen("sim/asym_mem_cases.txt", "r");
      if (fd == 0) begin
         other_errs++;
         $display("cases file sim/asym_mem_cases.txt could not be opened");
         return;
      end
      while (!$feof(fd)) begin
         line = '0;
         cnt  = $fgets(line, fd);
         // comment and blank lines do not yield five fields
         cnt = $sscanf(line, "%s %s %h %h %h", name, op, addr, data, exp_v);
         if (cnt == 5 && n_cases < MAX_CASES) begin
            case_name[n_cases] = name;
            case_op[n_cases]   = op;
            case_addr[n_cases] = addr;
            case_data[n_cases] = data;
            case_exp[n_cases]  = exp_v;
            n_cases++;
         end
      end
      $fclose(fd);
      if (n_cases == 0) begin
         other_errs++;
         $display("no cases were read from the cases file");
      end
   endtask

   task automatic run_cases();
      for (int i = 0; i < n_cases; i++) begin
         if (case_op[i] == "W") begin
            write_word(case_addr[i][WIDE_ADDR_W-1:0], case_data[i]);
         end else if (case_op[i] == "R") begin
            read_check(case_name[i], case_addr[i][DEF_ADDR_W-1:0], case_exp[i][R_W-1:0]);
         end else if (case_op[i] == "WAIT") begin
            hold_check(case_name[i], case_addr[i], case_exp[i][R_W-1:0]);
         end else begin
            other_errs++;
            $display("case %0s has an unknown operation", case_name[i]);
         end
      end
   endtask

   // one write and one read per cycle on a small window so addresses collide
   task automatic run_random();
      logic [31:0]    we;
      logic [31:0]    wa;
      logic [31:0]    wd;
      logic [31:0]    re;
      logic [31:0]    ra;
      logic [R_W-1:0] exp_rd;
      for (int k = 0; k < N_RAND; k++) begin
         take_bits(1, we);
         take_bits(3, wa);
         take_bits(32, wd);
         take_bits(1, re);
         take_bits(5, ra);
         // read-first, the read sees the model before this write
         exp_rd = re[0] ? model_mem[ra[4:0]] : last_rd;
         if (we[0]) begin
            model_write(wa[WIDE_ADDR_W-1:0], wd);
         end
         w_en_i   = we[0];
         w_addr_i = wa[WIDE_ADDR_W-1:0];
         w_data_i = wd;
         r_en_i   = re[0];
         r_addr_i = ra[DEF_ADDR_W-1:0];
         @(negedge clk_i);
         check_value("random", exp_rd, r_data_o);
         last_rd = exp_rd;
      end
      w_en_i = 1'b0;
      r_en_i = 1'b0;
   endtask

   initial begin
      while (cycle_cnt <= cycle_limit) begin
         @(posedge clk_i);
         cycle_cnt++;
      end
      $display("timeout after %0d cycles, the run did not complete", cycle_cnt);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      int busy_cycles;
      arst_n_i   = 1'b0;
      w_en_i     = 1'b0;
      w_addr_i   = '0;
      w_data_i   = '0;
      r_en_i     = 1'b0;
      r_addr_i   = '0;
      last_rd    = '0;
      lfsr_state = 32'h54c8_abea;
      for (int a = 0; a < NARROW_DEPTH; a++) begin
         model_mem[a] = '0;
      end
      load_cases();
      cycle_limit = 2 + CLR_CYCLES + NARROW_DEPTH + 3*n_cases + N_RAND + MARGIN;

      repeat (2) @(negedge clk_i);
      check_value("reset_busy", 1, clear_busy_o);
      check_value("reset_rdata", 0, r_data_o);
      arst_n_i = 1'b1;

      // write and read strobed partway through clearing
      w_addr_i    = 5;
      w_data_i    = 32'hdead_beef;
      r_addr_i    = 8'h14;
      busy_cycles = 0;
      while (clear_busy_o) begin
         w_en_i = (busy_cycles == BLOCKED_AT);
         r_en_i = (busy_cycles == BLOCKED_AT);
         @(negedge clk_i);
         busy_cycles++;
      end
      w_en_i = 1'b0;
      r_en_i = 1'b0;
      check_value("clear_cycles", CLR_CYCLES, busy_cycles);
      check_value("blocked_read", 0, r_data_o);

      // every narrow word reads zero, wide address 5 included
      for (int a = 0; a < NARROW_DEPTH; a++) begin
         read_check("clear_sweep", a[DEF_ADDR_W-1:0], model_mem[a]);
      end

      run_cases();
      run_random();

      $display("errors: %0d value, %0d other", value_errs, other_errs);
      if (value_errs + other_errs == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* all.f */
rtl/asym_cfg_pkg.sv
rtl/mem_ctrl_pkg.sv
rtl/lane_mem_if.sv
rtl/asym_port_converter.sv
rtl/mem_clear_ctrl.sv
rtl/lane_ram.sv
rtl/asym_mem_top.sv
sim/asym_mem_tb.sv

/* sim/asym_mem_cases.txt */
# columns: test name, op, address, write data, expected read data, all in hex
# W writes a wide word, R reads a narrow word, WAIT idles for address cycles checking hold
lane_w0       W     00  11223344  00
lane_r0_b0    R     00  00000000  44
lane_r0_b1    R     01  00000000  33
lane_r0_b2    R     02  00000000  22
lane_r0_b3    R     03  00000000  11
lane_w1       W     01  a5b6c7d8  00
lane_w63      W     3f  0f1e2d3c  00
lane_r1_b0    R     04  00000000  d8
lane_r1_b1    R     05  00000000  c7
lane_r1_b2    R     06  00000000  b6
lane_r1_b3    R     07  00000000  a5
lane_r63_b0   R     fc  00000000  3c
lane_r63_b1   R     fd  00000000  2d
lane_r63_b2   R     fe  00000000  1e
lane_r63_b3   R     ff  00000000  0f
lane_unset    R     08  00000000  00
lane_w20      W     14  deadbeef  00
lane_r20_b0   R     50  00000000  ef
lane_r20_b1   R     51  00000000  be
lane_r20_b2   R     52  00000000  ad
lane_r20_b3   R     53  00000000  de
hold_rd       R     05  00000000  c7
hold_idle     WAIT  04  00000000  c7
hold_w2       W     02  cafef00d  00
hold_wr       WAIT  03  00000000  c7
hold_w1       W     01  01020304  00
hold_after    WAIT  02  00000000  c7
hold_reread   R     05  00000000  03
ovr_r1_b0     R     04  00000000  04
ovr_r1_b3     R     07  00000000  01
lane_r2_b1    R     09  00000000  f0
lane_r2_b3    R     0b  00000000  ca
ovr_w0        W     00  ffffffff  00
ovr_r0_b2     R     02  00000000  ff
ovr_idle      WAIT  02  00000000  ff
lane_r2_b0    R     08  00000000  0d
lane_r2_b2    R     0a  00000000  fe
